//--- verilog/sram_pkg.sv
`default_nettype none

package sram_pkg;

    // One memory word, as stored in either chip.
    typedef logic [31:0] word_t;

    // A set bit means that byte lane is written.
    typedef logic [3:0] byte_mask_t;

    // Word address across both banks. Bit 0 selects the bank.
    typedef logic [19:0] word_addr_t;

    // Address within one chip.
    typedef logic [18:0] bank_addr_t;

    // Everything one chip is driven with. The tri-state buffer on dq
    // lives in the pad ring, so the output half and its enable are kept apart.
    typedef struct packed {
        logic       ce_n;
        logic       oe_n;
        logic       we_n;
        logic [3:0] be_n;
        bank_addr_t address;
        word_t      dq_out;
        logic       dq_oe;
    } bank_pins_t;

    // Which port the arbiter granted last.
    typedef enum logic {
        last_inst,
        last_data
    } arb_state_e;

endpackage

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef enum logic {
        op_read,
        op_write
    } data_op_e;

    // An instruction fetch always returns the words at addr and addr+1.
    typedef struct packed {
        sram_pkg::word_addr_t addr;
    } inst_req_t;

    typedef struct packed {
        data_op_e             op;
        sram_pkg::word_addr_t addr;
        sram_pkg::word_t      wdata;
        sram_pkg::byte_mask_t mask;
    } data_req_t;

    // Read response: word0 is at the request address, word1 at the next one.
    typedef struct packed {
        sram_pkg::word_t word0;
        sram_pkg::word_t word1;
    } pair_rsp_t;

    // One granted access on its way to the chips.
    typedef struct packed {
        logic                 is_write;
        sram_pkg::word_addr_t addr;
        sram_pkg::word_t      wdata;
        sram_pkg::byte_mask_t mask;
        logic                 port;
    } access_t;

endpackage

`default_nettype wire

//--- verilog/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter int  DEPTH = 4,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic push_valid,
    input  T     push_data,
    output logic head_valid,
    output T     head_data,
    input  logic pop,
    output logic credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // The requester only pushes while it holds a credit, so there is always room.
    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];
    assign do_pop     = pop && head_valid;

    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Each popped entry hands one credit back, one cycle later.
            credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

//--- verilog/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  bus_pkg::inst_req_t inst_head,
    input  logic               data_valid,
    input  bus_pkg::data_req_t data_head,
    output logic               inst_pop,
    output logic               data_pop,
    output logic               access_valid,
    output bus_pkg::access_t   access
);

    sram_pkg::arb_state_e state;
    logic                 grant_inst;
    logic                 grant_data;

    // On a tie the port that lost last time goes first.
    assign grant_inst = inst_valid && (!data_valid || state == sram_pkg::last_data);
    assign grant_data = data_valid && !grant_inst;

    assign inst_pop     = grant_inst;
    assign data_pop     = grant_data;
    assign access_valid = grant_inst || grant_data;

    always_comb begin
        if (grant_inst) begin
            access.is_write = 1'b0;
            access.addr     = inst_head.addr;
            access.wdata    = '0;
            access.mask     = '0;
            access.port     = 1'b0;
        end else begin
            access.is_write = (data_head.op == bus_pkg::op_write);
            access.addr     = data_head.addr;
            access.wdata    = data_head.wdata;
            access.mask     = data_head.mask;
            access.port     = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sram_pkg::last_data;
        end else if (grant_inst) begin
            state <= sram_pkg::last_inst;
        end else if (grant_data) begin
            state <= sram_pkg::last_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/interleave_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module interleave_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 access_valid,
    input  bus_pkg::access_t     access,
    output sram_pkg::bank_pins_t base_pins,
    output sram_pkg::bank_pins_t ext_pins,
    input  sram_pkg::word_t      base_dq_in,
    input  sram_pkg::word_t      ext_dq_in,
    output logic                 inst_rsp_valid,
    output bus_pkg::pair_rsp_t   inst_rsp,
    output logic                 data_rsp_valid,
    output bus_pkg::pair_rsp_t   data_rsp
);

    // Chip deselected, nothing driven.
    localparam sram_pkg::bank_pins_t IDLE_PINS = '{
        ce_n:    1'b1,
        oe_n:    1'b1,
        we_n:    1'b1,
        be_n:    4'hf,
        address: '0,
        dq_out:  '0,
        dq_oe:   1'b0
    };

    sram_pkg::bank_pins_t base_next;
    sram_pkg::bank_pins_t ext_next;
    sram_pkg::bank_addr_t half_addr;
    logic                 addr_even;

    // State of the access currently on the pins.
    logic                 pend_read;
    logic                 pend_port;
    logic                 pend_even;
    bus_pkg::pair_rsp_t   pair;

    assign half_addr = access.addr[19:1];
    assign addr_even = ~access.addr[0];

    always_comb begin
        base_next = IDLE_PINS;
        ext_next  = IDLE_PINS;
        if (access_valid) begin
            base_next.ce_n = 1'b0;
            ext_next.ce_n  = 1'b0;
            if (access.is_write) begin
                // Only the chip that owns the word sees we_n low.
                base_next.we_n    = ~addr_even;
                ext_next.we_n     = addr_even;
                base_next.be_n    = ~access.mask;
                ext_next.be_n     = ~access.mask;
                base_next.address = half_addr;
                ext_next.address  = half_addr;
                base_next.dq_out  = access.wdata;
                ext_next.dq_out   = access.wdata;
                base_next.dq_oe   = 1'b1;
                ext_next.dq_oe    = 1'b1;
            end else begin
                // An odd start puts the second word in the next base row.
                base_next.oe_n    = 1'b0;
                ext_next.oe_n     = 1'b0;
                base_next.address = addr_even ? half_addr : half_addr + 1'b1;
                ext_next.address  = half_addr;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_pins <= IDLE_PINS;
            ext_pins  <= IDLE_PINS;
            pend_read <= 1'b0;
            pend_port <= 1'b0;
            pend_even <= 1'b0;
        end else begin
            base_pins <= base_next;
            ext_pins  <= ext_next;
            pend_read <= access_valid && !access.is_write;
            pend_port <= access.port;
            pend_even <= addr_even;
        end
    end

    // The chips answer combinationally, so the read data is ready one edge later.
    always_comb begin
        pair.word0 = pend_even ? base_dq_in : ext_dq_in;
        pair.word1 = pend_even ? ext_dq_in : base_dq_in;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inst_rsp_valid <= 1'b0;
            data_rsp_valid <= 1'b0;
        end else begin
            inst_rsp_valid <= pend_read && !pend_port;
            data_rsp_valid <= pend_read && pend_port;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_read && !pend_port) begin
            inst_rsp <= pair;
        end
        if (pend_read && pend_port) begin
            data_rsp <= pair;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  bus_pkg::inst_req_t   inst_req,
    input  logic                 inst_req_valid,
    output logic                 inst_credit,
    input  bus_pkg::data_req_t   data_req,
    input  logic                 data_req_valid,
    output logic                 data_credit,
    output bus_pkg::pair_rsp_t   inst_rsp,
    output logic                 inst_rsp_valid,
    output bus_pkg::pair_rsp_t   data_rsp,
    output logic                 data_rsp_valid,
    output sram_pkg::bank_pins_t base_pins,
    output sram_pkg::bank_pins_t ext_pins,
    input  sram_pkg::word_t      base_dq_in,
    input  sram_pkg::word_t      ext_dq_in
);

    logic               inst_head_valid;
    bus_pkg::inst_req_t inst_head;
    logic               inst_pop;
    logic               data_head_valid;
    bus_pkg::data_req_t data_head;
    logic               data_pop;
    logic               access_valid;
    bus_pkg::access_t   access;

    req_queue #(
        .DEPTH (QUEUE_DEPTH),
        .T     (bus_pkg::inst_req_t)
    ) u_inst_queue (
        .clk        (clk),
        .rst        (rst),
        .push_valid (inst_req_valid),
        .push_data  (inst_req),
        .head_valid (inst_head_valid),
        .head_data  (inst_head),
        .pop        (inst_pop),
        .credit     (inst_credit)
    );

    req_queue #(
        .DEPTH (QUEUE_DEPTH),
        .T     (bus_pkg::data_req_t)
    ) u_data_queue (
        .clk        (clk),
        .rst        (rst),
        .push_valid (data_req_valid),
        .push_data  (data_req),
        .head_valid (data_head_valid),
        .head_data  (data_head),
        .pop        (data_pop),
        .credit     (data_credit)
    );

    port_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_head_valid),
        .inst_head    (inst_head),
        .data_valid   (data_head_valid),
        .data_head    (data_head),
        .inst_pop     (inst_pop),
        .data_pop     (data_pop),
        .access_valid (access_valid),
        .access       (access)
    );

    interleave_ctrl u_interleave (
        .clk            (clk),
        .rst            (rst),
        .access_valid   (access_valid),
        .access         (access),
        .base_pins      (base_pins),
        .ext_pins       (ext_pins),
        .base_dq_in     (base_dq_in),
        .ext_dq_in      (ext_dq_in),
        .inst_rsp_valid (inst_rsp_valid),
        .inst_rsp       (inst_rsp),
        .data_rsp_valid (data_rsp_valid),
        .data_rsp       (data_rsp)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset drops 1 ns after its last edge, in step with the other stimulus.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/sram_bank_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank_model #(
    parameter logic BANK_BIT = 1'b0
) (
    input  logic                 clk,
    input  sram_pkg::bank_pins_t pins,
    output sram_pkg::word_t      dq_in
);

    localparam int WORDS = 1 << 19;

    sram_pkg::word_t mem [WORDS];

    // Every word starts out holding a pattern of its own word address.
    initial begin
        sram_pkg::word_addr_t word_addr;
        for (int i = 0; i < WORDS; i++) begin
            word_addr = {sram_pkg::bank_addr_t'(i), BANK_BIT};
            mem[i] <= {~word_addr[11:0], word_addr};
        end
    end

    assign dq_in = (!pins.ce_n && !pins.oe_n) ? mem[pins.address] : '0;

    // The chip only sees write data while the pad drives dq.
    always @(posedge clk) begin
        if (!pins.ce_n && !pins.we_n && pins.dq_oe) begin
            for (int i = 0; i < 4; i++) begin
                if (!pins.be_n[i]) begin
                    mem[pins.address][8 * i +: 8] <= pins.dq_out[8 * i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_sram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_subsystem;

    localparam int QUEUE_DEPTH     = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int N_PRELOAD       = 48;
    localparam int N_MASKED        = 32;
    localparam int N_FETCH         = 40;
    localparam int N_CONC          = 80;
    localparam int TOTAL_REQS      = 2 * N_PRELOAD + 2 * N_MASKED + N_FETCH + 2 + 2 * N_CONC;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_REQS * 4 * (QUEUE_DEPTH + 4);
    // Data traffic in the concurrent phase stays clear of the fetched region.
    localparam sram_pkg::word_addr_t CONC_BASE = 20'h80000;

    logic                 clk;
    logic                 rst;
    bus_pkg::inst_req_t   inst_req;
    logic                 inst_req_valid;
    logic                 inst_credit;
    bus_pkg::data_req_t   data_req;
    logic                 data_req_valid;
    logic                 data_credit;
    bus_pkg::pair_rsp_t   inst_rsp;
    logic                 inst_rsp_valid;
    bus_pkg::pair_rsp_t   data_rsp;
    logic                 data_rsp_valid;
    sram_pkg::bank_pins_t base_pins;
    sram_pkg::bank_pins_t ext_pins;
    sram_pkg::word_t      base_dq_in;
    sram_pkg::word_t      ext_dq_in;

    sram_pkg::word_t      ref_mem [0:(1 << 20) - 1];
    bus_pkg::pair_rsp_t   inst_exp [$];
    bus_pkg::pair_rsp_t   data_exp [$];
    sram_pkg::word_addr_t written [$];
    string                test_name = "reset";
    int                   inst_issued = 0;
    int                   data_issued = 0;
    int                   inst_returned = 0;
    int                   data_returned = 0;
    int                   inst_seen = 0;
    int                   data_seen = 0;
    int                   errors = 0;
    int                   mon_errors = 0;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .rst(rst));

    sram_subsystem #(.QUEUE_DEPTH(QUEUE_DEPTH)) UUT (.*);

    sram_bank_model #(.BANK_BIT(1'b0)) u_base_bank (
        .clk   (clk),
        .pins  (base_pins),
        .dq_in (base_dq_in)
    );
    sram_bank_model #(.BANK_BIT(1'b1)) u_ext_bank (
        .clk   (clk),
        .pins  (ext_pins),
        .dq_in (ext_dq_in)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic sram_pkg::word_t fill_word(input sram_pkg::word_addr_t addr);
        return {~addr[11:0], addr};
    endfunction

    function automatic sram_pkg::word_addr_t rand_low_addr();
        return sram_pkg::word_addr_t'($urandom_range(255));
    endfunction

    // The word after the top address is word 0, as base[h+1] wraps in the chip.
    function automatic bus_pkg::pair_rsp_t expected_pair(input sram_pkg::word_addr_t addr);
        bus_pkg::pair_rsp_t   pair;
        sram_pkg::word_addr_t next_addr;
        next_addr  = addr + 1'b1;
        pair.word0 = ref_mem[addr];
        pair.word1 = ref_mem[next_addr];
        return pair;
    endfunction

    task automatic check_pair(input string name, input bus_pkg::pair_rsp_t exp,
                              input bus_pkg::pair_rsp_t act);
        if (act !== exp) begin
            mon_errors++;
            $display("[FAIL] %s: expected %h %h, actual %h %h",
                     name, exp.word0, exp.word1, act.word0, act.word1);
        end
    endtask

    task automatic check_credit_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_logic(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_idle_outputs();
        check_logic({test_name, " inst_rsp_valid"}, 1'b0, inst_rsp_valid);
        check_logic({test_name, " data_rsp_valid"}, 1'b0, data_rsp_valid);
        check_logic({test_name, " inst_credit"}, 1'b0, inst_credit);
        check_logic({test_name, " data_credit"}, 1'b0, data_credit);
        check_logic({test_name, " base ce_n"}, 1'b1, base_pins.ce_n);
        check_logic({test_name, " base we_n"}, 1'b1, base_pins.we_n);
        check_logic({test_name, " ext ce_n"}, 1'b1, ext_pins.ce_n);
        check_logic({test_name, " ext we_n"}, 1'b1, ext_pins.we_n);
    endtask

    task automatic send_inst(input sram_pkg::word_addr_t addr);
        while (inst_issued - inst_returned >= QUEUE_DEPTH) begin
            next_cycle();
        end
        inst_exp.push_back(expected_pair(addr));
        inst_issued++;
        inst_req.addr  = addr;
        inst_req_valid = 1'b1;
        next_cycle();
        inst_req_valid = 1'b0;
    endtask

    task automatic send_data(input bus_pkg::data_op_e op, input sram_pkg::word_addr_t addr,
                             input sram_pkg::word_t wdata, input sram_pkg::byte_mask_t mask);
        while (data_issued - data_returned >= QUEUE_DEPTH) begin
            next_cycle();
        end
        if (op == bus_pkg::op_write) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    ref_mem[addr][8 * i +: 8] = wdata[8 * i +: 8];
                end
            end
        end else begin
            data_exp.push_back(expected_pair(addr));
        end
        data_issued++;
        data_req       = '{op: op, addr: addr, wdata: wdata, mask: mask};
        data_req_valid = 1'b1;
        next_cycle();
        data_req_valid = 1'b0;
    endtask

    task automatic drain();
        while (inst_seen < inst_exp.size() || data_seen < data_exp.size()) begin
            next_cycle();
        end
        // Every queued entry is granted within 2 * QUEUE_DEPTH cycles, its credit a cycle later.
        repeat (2 * QUEUE_DEPTH + 2) next_cycle();
    endtask

    task automatic check_outstanding(input string port, input int issued, input int returned);
        if (returned > issued) begin
            mon_errors++;
            $display("The %s port returned more credits than it was sent requests.", port);
        end
    endtask

    // Outputs are sampled on the falling edge, halfway between register updates.
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (inst_credit) inst_returned++;
                if (data_credit) data_returned++;
                check_outstanding("instruction", inst_issued, inst_returned);
                check_outstanding("data", data_issued, data_returned);
                if (inst_rsp_valid) begin
                    if (inst_seen < inst_exp.size()) begin
                        check_pair({test_name, " fetch"}, inst_exp[inst_seen], inst_rsp);
                    end else begin
                        mon_errors++;
                        $display("The instruction port returned a pair with no fetch pending.");
                    end
                    inst_seen++;
                end
                if (data_rsp_valid) begin
                    if (data_seen < data_exp.size()) begin
                        check_pair({test_name, " data read"}, data_exp[data_seen], data_rsp);
                    end else begin
                        mon_errors++;
                        $display("The data port returned a pair with no read pending.");
                    end
                    data_seen++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with traffic still pending.", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        sram_pkg::word_addr_t addr;
        sram_pkg::byte_mask_t mask;
        void'($urandom(23));
        inst_req       = '0;
        inst_req_valid = 1'b0;
        data_req       = '0;
        data_req_valid = 1'b0;
        for (int i = 0; i < (1 << 20); i++) begin
            ref_mem[i] = fill_word(sram_pkg::word_addr_t'(i));
        end

        @(negedge clk);
        while (rst) begin
            check_idle_outputs();
            @(negedge clk);
        end
        test_name = "after reset";
        repeat (2) begin
            check_idle_outputs();
            @(negedge clk);
        end

        test_name = "preload";
        next_cycle();
        repeat (N_PRELOAD) begin
            addr = rand_low_addr();
            written.push_back(addr);
            send_data(bus_pkg::op_write, addr, $urandom, 4'hf);
        end
        repeat (N_PRELOAD) begin
            addr = written[$urandom_range(N_PRELOAD - 1)];
            send_data(bus_pkg::op_read, addr + sram_pkg::word_addr_t'($urandom_range(1)), '0, '0);
        end
        drain();

        test_name = "masked";
        repeat (N_MASKED) begin
            addr = rand_low_addr();
            mask = sram_pkg::byte_mask_t'($urandom_range(15, 1));
            send_data(bus_pkg::op_write, addr, $urandom, mask);
            // Reading from the word below puts the neighbor in word0.
            send_data(bus_pkg::op_read, addr - sram_pkg::word_addr_t'($urandom_range(1)), '0, '0);
        end
        drain();

        test_name = "fetch";
        send_inst(20'hfffff);
        send_inst(20'hffffe);
        repeat (N_FETCH) send_inst(rand_low_addr());
        drain();

        test_name = "concurrent";
        fork
            repeat (N_CONC) begin
                send_inst(rand_low_addr());
                repeat ($urandom_range(2)) next_cycle();
            end
            repeat (N_CONC) begin
                send_data(($urandom_range(1) == 1) ? bus_pkg::op_write : bus_pkg::op_read,
                          CONC_BASE + rand_low_addr(), $urandom,
                          sram_pkg::byte_mask_t'($urandom));
                repeat ($urandom_range(2)) next_cycle();
            end
        join
        drain();

        test_name = "credits";
        check_credit_count("inst credits returned", inst_issued, inst_returned);
        check_credit_count("data credits returned", data_issued, data_returned);
        check_credit_count("inst credits held", QUEUE_DEPTH,
                           QUEUE_DEPTH - inst_issued + inst_returned);
        check_credit_count("data credits held", QUEUE_DEPTH,
                           QUEUE_DEPTH - data_issued + data_returned);

        $display("Responses checked: %0d, response and credit errors: %0d, other errors: %0d",
                 inst_seen + data_seen, mon_errors, errors);
        if (errors + mon_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/sram_pkg.sv
verilog/bus_pkg.sv
verilog/req_queue.sv
verilog/port_arbiter.sv
verilog/interleave_ctrl.sv
verilog/sram_subsystem.sv
verif/tb_clock_gen.sv
verif/sram_bank_model.sv
verif/tb_sram_subsystem.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_sram_subsystem \
    -f files.f --Mdir obj_dir -o sim_tb_sram_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_sram_subsystem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
